// ==== design/mips_exec_pkg.sv ====
`default_nettype none

package mips_exec_pkg;

  localparam int XLEN         = 32;
  localparam int MULDIV_STEPS = 32;
  localparam int MD_CNT_W     = $clog2(MULDIV_STEPS);
  localparam logic [MD_CNT_W-1:0] MD_LAST = MD_CNT_W'(MULDIV_STEPS - 1);

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_REGIMM  = 6'h01,          // BLTZ, BGEZ and the AL forms
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_BLEZ    = 6'h06,
    OP_BGTZ    = 6'h07,
    OP_ADDI    = 6'h08,          // No overflow trap here
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_SLTIU   = 6'h0b,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LUI     = 6'h0f,
    OP_LB      = 6'h20,
    OP_LH      = 6'h21,
    OP_LW      = 6'h23,
    OP_LBU     = 6'h24,
    OP_LHU     = 6'h25,
    OP_SB      = 6'h28,
    OP_SH      = 6'h29,
    OP_SW      = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    F_SLL   = 6'h00,
    F_SRL   = 6'h02,
    F_SRA   = 6'h03,
    F_SLLV  = 6'h04,
    F_SRLV  = 6'h06,
    F_SRAV  = 6'h07,
    F_MFHI  = 6'h10,
    F_MTHI  = 6'h11,
    F_MFLO  = 6'h12,
    F_MTLO  = 6'h13,
    F_MULT  = 6'h18,
    F_MULTU = 6'h19,
    F_DIV   = 6'h1a,
    F_DIVU  = 6'h1b,
    F_ADD   = 6'h20,
    F_ADDU  = 6'h21,
    F_SUB   = 6'h22,
    F_SUBU  = 6'h23,
    F_AND   = 6'h24,
    F_OR    = 6'h25,
    F_XOR   = 6'h26,
    F_SLT   = 6'h2a,
    F_SLTU  = 6'h2b
  } funct_e;

  typedef enum logic [3:0] {
    ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL,
    ALU_SRA, ALU_SLT, ALU_SLTU, ALU_LUI, ALU_PASS_HI, ALU_PASS_LO
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LTZ, BR_GEZ, BR_GTZ, BR_LEZ
  } branch_cond_e;

  typedef enum logic [2:0] {
    MD_NONE, MD_MULT, MD_MULTU, MD_DIV, MD_DIVU
  } muldiv_op_e;

  typedef struct packed {
    logic [31:0]     instruction;
    logic [XLEN-1:0] rs_val;
    logic [XLEN-1:0] rt_val;
  } exec_req_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            branch_taken;
    logic            wr_reg;
    logic            illegal;
  } exec_resp_t;

  typedef struct packed {
    alu_op_e         alu_op;
    branch_cond_e    branch_cond;
    muldiv_op_e      muldiv_op;
    logic            use_imm;
    logic            imm_signed;
    logic            shift_by_reg;
    logic [4:0]      shamt;
    logic [XLEN-1:0] imm;
    logic            mthi;
    logic            mtlo;
    logic            wr_reg;
    logic            illegal;
  } decoded_t;

  typedef struct packed {
    logic [XLEN-1:0] hi;
    logic [XLEN-1:0] lo;
  } hilo_t;

endpackage

`default_nettype wire

// ==== design/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
  input  logic [31:0]            instr,
  output mips_exec_pkg::decoded_t dec
);

  logic [5:0]  opcode;
  logic [5:0]  funct;
  logic [4:0]  rt;
  logic [15:0] imm16;

  assign opcode = instr[31:26];
  assign rt     = instr[20:16];
  assign funct  = instr[5:0];
  assign imm16  = instr[15:0];

  always_comb
  begin
    dec              = '0;
    dec.alu_op       = mips_exec_pkg::ALU_NONE;
    dec.branch_cond  = mips_exec_pkg::BR_NONE;
    dec.muldiv_op    = mips_exec_pkg::MD_NONE;
    dec.shamt        = instr[10:6];
    dec.wr_reg       = 1'b1;
    dec.imm_signed   = 1'b1;                     // Zero extension is the exception
    case (mips_exec_pkg::opcode_e'(opcode))
      mips_exec_pkg::OP_SPECIAL:
      begin
        case (mips_exec_pkg::funct_e'(funct))
          mips_exec_pkg::F_SLL:  dec.alu_op = mips_exec_pkg::ALU_SLL;
          mips_exec_pkg::F_SRL:  dec.alu_op = mips_exec_pkg::ALU_SRL;
          mips_exec_pkg::F_SRA:  dec.alu_op = mips_exec_pkg::ALU_SRA;
          mips_exec_pkg::F_SLLV:
          begin
            dec.alu_op       = mips_exec_pkg::ALU_SLL;
            dec.shift_by_reg = 1'b1;
          end
          mips_exec_pkg::F_SRLV:
          begin
            dec.alu_op       = mips_exec_pkg::ALU_SRL;
            dec.shift_by_reg = 1'b1;
          end
          mips_exec_pkg::F_SRAV:
          begin
            dec.alu_op       = mips_exec_pkg::ALU_SRA;
            dec.shift_by_reg = 1'b1;
          end
          mips_exec_pkg::F_MFHI: dec.alu_op = mips_exec_pkg::ALU_PASS_HI;
          mips_exec_pkg::F_MFLO: dec.alu_op = mips_exec_pkg::ALU_PASS_LO;
          mips_exec_pkg::F_MTHI:
          begin
            dec.mthi   = 1'b1;
            dec.wr_reg = 1'b0;
          end
          mips_exec_pkg::F_MTLO:
          begin
            dec.mtlo   = 1'b1;
            dec.wr_reg = 1'b0;
          end
          mips_exec_pkg::F_MULT:
          begin
            dec.muldiv_op = mips_exec_pkg::MD_MULT;
            dec.wr_reg    = 1'b0;
          end
          mips_exec_pkg::F_MULTU:
          begin
            dec.muldiv_op = mips_exec_pkg::MD_MULTU;
            dec.wr_reg    = 1'b0;
          end
          mips_exec_pkg::F_DIV:
          begin
            dec.muldiv_op = mips_exec_pkg::MD_DIV;
            dec.wr_reg    = 1'b0;
          end
          mips_exec_pkg::F_DIVU:
          begin
            dec.muldiv_op = mips_exec_pkg::MD_DIVU;
            dec.wr_reg    = 1'b0;
          end
          mips_exec_pkg::F_ADD, mips_exec_pkg::F_ADDU: dec.alu_op = mips_exec_pkg::ALU_ADD;
          mips_exec_pkg::F_SUB, mips_exec_pkg::F_SUBU: dec.alu_op = mips_exec_pkg::ALU_SUB;
          mips_exec_pkg::F_AND:  dec.alu_op = mips_exec_pkg::ALU_AND;
          mips_exec_pkg::F_OR:   dec.alu_op = mips_exec_pkg::ALU_OR;
          mips_exec_pkg::F_XOR:  dec.alu_op = mips_exec_pkg::ALU_XOR;
          mips_exec_pkg::F_SLT:  dec.alu_op = mips_exec_pkg::ALU_SLT;
          mips_exec_pkg::F_SLTU: dec.alu_op = mips_exec_pkg::ALU_SLTU;
          default:               dec.illegal = 1'b1;
        endcase
      end
      mips_exec_pkg::OP_REGIMM:
      begin
        dec.wr_reg = 1'b0;
        case (rt)
          5'h00, 5'h10: dec.branch_cond = mips_exec_pkg::BR_LTZ;   // BLTZ, BLTZAL
          5'h01, 5'h11: dec.branch_cond = mips_exec_pkg::BR_GEZ;   // BGEZ, BGEZAL
          default:      dec.illegal     = 1'b1;
        endcase
      end
      mips_exec_pkg::OP_BEQ:
      begin
        dec.branch_cond = mips_exec_pkg::BR_EQ;
        dec.wr_reg      = 1'b0;
      end
      mips_exec_pkg::OP_BNE:
      begin
        dec.branch_cond = mips_exec_pkg::BR_NE;
        dec.wr_reg      = 1'b0;
      end
      mips_exec_pkg::OP_BLEZ:
      begin
        dec.branch_cond = mips_exec_pkg::BR_LEZ;
        dec.wr_reg      = 1'b0;
        dec.illegal     = (rt != 5'd0);                // rt must be zero
      end
      mips_exec_pkg::OP_BGTZ:
      begin
        dec.branch_cond = mips_exec_pkg::BR_GTZ;
        dec.wr_reg      = 1'b0;
        dec.illegal     = (rt != 5'd0);
      end
      mips_exec_pkg::OP_ADDI, mips_exec_pkg::OP_ADDIU,
      mips_exec_pkg::OP_LB, mips_exec_pkg::OP_LH, mips_exec_pkg::OP_LW,
      mips_exec_pkg::OP_LBU, mips_exec_pkg::OP_LHU,
      mips_exec_pkg::OP_SB, mips_exec_pkg::OP_SH, mips_exec_pkg::OP_SW:
      begin
        dec.alu_op  = mips_exec_pkg::ALU_ADD;          // Also the memory address
        dec.use_imm = 1'b1;
      end
      mips_exec_pkg::OP_SLTI:
      begin
        dec.alu_op  = mips_exec_pkg::ALU_SLT;
        dec.use_imm = 1'b1;
      end
      mips_exec_pkg::OP_SLTIU:
      begin
        dec.alu_op  = mips_exec_pkg::ALU_SLTU;         // Sign-extended, compared unsigned
        dec.use_imm = 1'b1;
      end
      mips_exec_pkg::OP_ANDI, mips_exec_pkg::OP_ORI, mips_exec_pkg::OP_XORI,
      mips_exec_pkg::OP_LUI:
      begin
        dec.use_imm    = 1'b1;
        dec.imm_signed = 1'b0;
        case (mips_exec_pkg::opcode_e'(opcode))
          mips_exec_pkg::OP_ANDI: dec.alu_op = mips_exec_pkg::ALU_AND;
          mips_exec_pkg::OP_ORI:  dec.alu_op = mips_exec_pkg::ALU_OR;
          mips_exec_pkg::OP_XORI: dec.alu_op = mips_exec_pkg::ALU_XOR;
          default:                dec.alu_op = mips_exec_pkg::ALU_LUI;
        endcase
      end
      default: dec.illegal = 1'b1;
    endcase

    dec.imm = dec.imm_signed ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};

    if (dec.illegal)
    begin
      dec.wr_reg      = 1'b0;
      dec.branch_cond = mips_exec_pkg::BR_NONE;
    end
  end

endmodule

`default_nettype wire

// ==== design/int_alu.sv ====
`default_nettype none

module int_alu (
  input  mips_exec_pkg::decoded_t        dec,
  input  logic [mips_exec_pkg::XLEN-1:0] rs_val,
  input  logic [mips_exec_pkg::XLEN-1:0] rt_val,
  input  mips_exec_pkg::hilo_t           hilo,
  output logic [mips_exec_pkg::XLEN-1:0] result,
  output logic                           branch_taken
);

  logic [mips_exec_pkg::XLEN-1:0] op_b;
  logic [4:0]                     sh_amt;

  assign op_b   = dec.use_imm ? dec.imm : rt_val;
  assign sh_amt = dec.shift_by_reg ? rs_val[4:0] : dec.shamt;   // Only rs[4:0] counts

  always_comb
  begin
    case (dec.alu_op)
      mips_exec_pkg::ALU_ADD:     result = rs_val + op_b;
      mips_exec_pkg::ALU_SUB:     result = rs_val - op_b;
      mips_exec_pkg::ALU_AND:     result = rs_val & op_b;
      mips_exec_pkg::ALU_OR:      result = rs_val | op_b;
      mips_exec_pkg::ALU_XOR:     result = rs_val ^ op_b;
      mips_exec_pkg::ALU_SLL:     result = rt_val << sh_amt;
      mips_exec_pkg::ALU_SRL:     result = rt_val >> sh_amt;
      mips_exec_pkg::ALU_SRA:     result = $signed(rt_val) >>> sh_amt;
      mips_exec_pkg::ALU_SLT:
      begin
        result    = '0;
        result[0] = $signed(rs_val) < $signed(op_b);
      end
      mips_exec_pkg::ALU_SLTU:
      begin
        result    = '0;
        result[0] = rs_val < op_b;
      end
      mips_exec_pkg::ALU_LUI:     result = {op_b[15:0], 16'h0000};
      mips_exec_pkg::ALU_PASS_HI: result = hilo.hi;
      mips_exec_pkg::ALU_PASS_LO: result = hilo.lo;
      default:                    result = '0;
    endcase
  end

  // Branch decision only; target and link address live outside
  always_comb
  begin
    case (dec.branch_cond)
      mips_exec_pkg::BR_EQ:  branch_taken = (rs_val == rt_val);
      mips_exec_pkg::BR_NE:  branch_taken = (rs_val != rt_val);
      mips_exec_pkg::BR_LTZ: branch_taken = rs_val[mips_exec_pkg::XLEN-1];
      mips_exec_pkg::BR_GEZ: branch_taken = !rs_val[mips_exec_pkg::XLEN-1];
      mips_exec_pkg::BR_GTZ: branch_taken = $signed(rs_val) > 0;
      mips_exec_pkg::BR_LEZ: branch_taken = $signed(rs_val) <= 0;
      default:               branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/muldiv_unit.sv ====
`default_nettype none

module muldiv_unit (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start,
  input  mips_exec_pkg::muldiv_op_e      op,
  input  logic [mips_exec_pkg::XLEN-1:0] a,
  input  logic [mips_exec_pkg::XLEN-1:0] b,
  output logic                           busy,
  output logic                           done,
  output mips_exec_pkg::hilo_t           res
);

  localparam int W = mips_exec_pkg::XLEN;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    FIX
  } state_e;

  state_e                             state;
  logic [mips_exec_pkg::MD_CNT_W-1:0] count;
  logic [2*W-1:0]                     work;      // Product, or remainder and quotient
  logic [W-1:0]                       divisor;   // Magnitude of b
  logic                               is_div;
  logic                               neg_q;     // Negate product or quotient
  logic                               neg_r;     // Negate remainder
  logic                               signed_op;
  logic                               a_neg;
  logic                               b_neg;
  logic [W-1:0]                       mag_a;
  logic [W-1:0]                       mag_b;
  logic [W:0]                         mul_sum;
  logic [W:0]                         part;
  logic [W+1:0]                       diff;

  assign signed_op = (op == mips_exec_pkg::MD_MULT) || (op == mips_exec_pkg::MD_DIV);
  assign a_neg     = signed_op && a[W-1];
  assign b_neg     = signed_op && b[W-1];
  assign mag_a     = a_neg ? -a : a;
  assign mag_b     = b_neg ? -b : b;

  assign mul_sum = {1'b0, work[2*W-1:W]} + (work[0] ? {1'b0, divisor} : {(W+1){1'b0}});
  assign part    = work[2*W-1:W-1];                       // Remainder after shift
  assign diff    = {1'b0, part} - {2'b00, divisor};

  assign busy = (state != IDLE);
  assign done = (state == FIX);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= IDLE;
      count <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          count <= '0;
          if (start)
            state <= RUN;
        end
        RUN:
        begin
          count <= count + 1'b1;
          if (count == mips_exec_pkg::MD_LAST)
            state <= FIX;
        end
        default: state <= IDLE;                            // FIX lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IDLE && start)
    begin
      work    <= {{W{1'b0}}, mag_a};
      divisor <= mag_b;
      is_div  <= (op == mips_exec_pkg::MD_DIV) || (op == mips_exec_pkg::MD_DIVU);
      neg_q   <= (a_neg ^ b_neg) && (b != '0);             // Div by zero keeps all ones
      neg_r   <= a_neg;
    end
    else if (state == RUN)
    begin
      if (is_div)
        work <= diff[W+1] ? {work[2*W-2:0], 1'b0} : {diff[W-1:0], work[W-2:0], 1'b1};
      else
        work <= {mul_sum, work[W-1:1]};                    // Shift-add step
    end
  end

  // Sign fix-up, valid while done is high
  always_comb
  begin
    res = mips_exec_pkg::hilo_t'(work);
    if (!is_div && neg_q)
      res = mips_exec_pkg::hilo_t'(-work);
    if (is_div && neg_q)
      res.lo = -work[W-1:0];
    if (is_div && neg_r)
      res.hi = -work[2*W-1:W];
  end

  a_no_start_busy : assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
    else $error("muldiv start while busy");

endmodule

`default_nettype wire

// ==== design/hilo_regs.sv ====
`default_nettype none

module hilo_regs (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           md_done,
  input  mips_exec_pkg::hilo_t           md_res,
  input  logic                           wr_hi,
  input  logic                           wr_lo,
  input  logic [mips_exec_pkg::XLEN-1:0] wdata,
  output mips_exec_pkg::hilo_t           hilo
);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      hilo <= '0;
    else if (md_done)
      hilo <= md_res;                 // Both halves from the mul/div unit
    else
    begin
      if (wr_hi)
        hilo.hi <= wdata;
      if (wr_lo)
        hilo.lo <= wdata;
    end
  end

  // The interlock keeps MTHI/MTLO away from the last mul/div cycle
  a_no_write_clash : assert property (
    @(posedge clk) disable iff (!rst_n) md_done |-> !(wr_hi || wr_lo))
    else $error("MT write coincides with muldiv done");

endmodule

`default_nettype wire

// ==== design/mips_execute.sv ====
`default_nettype none

module mips_execute (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  mips_exec_pkg::exec_req_t  in_req,
  output logic                      out_valid,
  input  logic                      out_ready,
  output mips_exec_pkg::exec_resp_t out_resp
);

  mips_exec_pkg::decoded_t        dec;
  mips_exec_pkg::hilo_t           hilo;
  mips_exec_pkg::hilo_t           md_res;
  logic [mips_exec_pkg::XLEN-1:0] alu_result;
  logic                           branch_taken;
  logic                           md_busy;
  logic                           md_done;
  logic                           md_start;
  logic                           hilo_dep;
  logic                           out_free;
  logic                           accept;
  logic                           init_done;

  instr_decoder instr_decoder_i (
    .instr (in_req.instruction),
    .dec   (dec)
  );

  int_alu int_alu_i (
    .dec          (dec),
    .rs_val       (in_req.rs_val),
    .rt_val       (in_req.rt_val),
    .hilo         (hilo),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  muldiv_unit muldiv_unit_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (md_start),
    .op    (dec.muldiv_op),
    .a     (in_req.rs_val),
    .b     (in_req.rt_val),
    .busy  (md_busy),
    .done  (md_done),
    .res   (md_res)
  );

  hilo_regs hilo_regs_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .md_done (md_done),
    .md_res  (md_res),
    .wr_hi   (accept && dec.mthi),
    .wr_lo   (accept && dec.mtlo),
    .wdata   (in_req.rs_val),
    .hilo    (hilo)
  );

  // Anything touching HI/LO waits for the mul/div unit
  assign hilo_dep = (dec.muldiv_op != mips_exec_pkg::MD_NONE) || dec.mthi || dec.mtlo ||
                    (dec.alu_op == mips_exec_pkg::ALU_PASS_HI) ||
                    (dec.alu_op == mips_exec_pkg::ALU_PASS_LO);

  assign out_free = !out_valid || out_ready;
  assign in_ready = init_done && out_free && !(md_busy && hilo_dep);
  assign accept   = in_valid && in_ready;
  assign md_start = accept && (dec.muldiv_op != mips_exec_pkg::MD_NONE);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      init_done <= 1'b0;
      out_valid <= 1'b0;
    end
    else
    begin
      init_done <= 1'b1;                                   // Ready from 2nd cycle on
      if (accept)
        out_valid <= 1'b1;
      else if (out_ready)
        out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      out_resp.result       <= alu_result;
      out_resp.branch_taken <= branch_taken;
      out_resp.wr_reg       <= dec.wr_reg;
      out_resp.illegal      <= dec.illegal;
    end
  end

  a_out_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_resp))
    else $error("out_resp changed under back-pressure");

endmodule

`default_nettype wire

// ==== testbench/mips_execute_tb.sv ====
`default_nettype none

module mips_execute_tb;

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] result;
    logic        branch_taken;
    logic        wr_reg;
    logic        illegal;
  } test_t;

  logic                      clk;
  logic                      rst_n;
  logic                      in_valid;
  logic                      in_ready;
  mips_exec_pkg::exec_req_t  in_req;
  logic                      out_valid;
  logic                      out_ready;
  mips_exec_pkg::exec_resp_t out_resp;

  test_t  tests[$];
  integer seed;
  int     received;
  int     cycles;
  int     cycle_limit;
  bit     extra;

  mips_execute mips_execute_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_resp  (out_resp)
  );

  always #4 clk = ~clk;                                  // 8 ns period

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > cycle_limit)
      fail_run($sformatf("Timeout after %0d cycles, %0d of %0d responses received",
                         cycles, received, tests.size()));
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected)
      fail_run($sformatf("MISMATCH at %0t ns: %s is %08h, expected %08h",
                         $time, what, got, expected));
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [7];
    test_t       t;
    fd = $fopen("testbench/execute_tests.txt", "r");
    if (fd == 0)
      fail_run("Could not open the test file testbench/execute_tests.txt");
    while ($fgets(line, fd) != 0)
    begin
      n = $sscanf(line, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
      if (n == 7)
      begin
        t.instr        = f[0];
        t.rs_val       = f[1];
        t.rt_val       = f[2];
        t.result       = f[3];
        t.branch_taken = f[4][0];
        t.wr_reg       = f[5][0];
        t.illegal      = f[6][0];
        tests.push_back(t);
      end
      else if (n > 0)
        fail_run($sformatf("Test file line has %0d fields instead of 7: %s", n, line));
    end
    $fclose(fd);
  endtask

  // Result only matters when a register is written
  task automatic check_response(input test_t t, input int idx);
    if (t.wr_reg)
      check_value(out_resp.result, t.result, $sformatf("test %0d result", idx));
    check_value({31'b0, out_resp.branch_taken}, {31'b0, t.branch_taken},
                $sformatf("test %0d branch_taken", idx));
    check_value({31'b0, out_resp.wr_reg}, {31'b0, t.wr_reg},
                $sformatf("test %0d wr_reg", idx));
    check_value({31'b0, out_resp.illegal}, {31'b0, t.illegal},
                $sformatf("test %0d illegal", idx));
  endtask

  task automatic drive_requests();
    bit taken;
    int i;
    for (i = 0; i < tests.size(); i++)
    begin
      in_req.instruction = tests[i].instr;
      in_req.rs_val      = tests[i].rs_val;
      in_req.rt_val      = tests[i].rt_val;
      in_valid           = 1'b1;
      taken              = 1'b0;
      while (!taken)
      begin
        @(negedge clk);
        taken = in_ready;                                // Transfer on the coming edge
        @(posedge clk);
      end
      #1;
    end
    in_valid = 1'b0;
    in_req   = '0;
  endtask

  task automatic collect_responses();
    while (received < tests.size())
    begin
      out_ready = ($random(seed) & 3) != 0;              // Stall about one cycle in four
      @(negedge clk);
      if (out_valid && out_ready)
      begin
        check_response(tests[received], received);
        received++;
      end
      @(posedge clk);
      #1;
    end
  endtask

  initial
  begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_req      = '0;
    out_ready   = 1'b0;
    seed        = 64;
    received    = 0;
    cycles      = 0;
    cycle_limit = 100;
    extra       = 1'b0;
    load_tests();
    if (tests.size() == 0)
      fail_run("No tests found in testbench/execute_tests.txt");
    cycle_limit = tests.size() * 40 + 100;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    fork
      drive_requests();
      collect_responses();
    join
    out_ready = 1'b1;
    repeat (3)
    begin
      @(negedge clk);
      if (out_valid)
        extra = 1'b1;                                    // Nothing left to answer
    end
    if (!extra && received == tests.size())
    begin
      $display("TESTBENCH PASSED");
      $finish;
    end
    else
      fail_run($sformatf("Wrong response count: %0d sent, %0d received, extra response %0b",
                         tests.size(), received, extra));
  end

endmodule

`default_nettype wire

// ==== testbench/execute_tests.txt ====
# Columns in hex: instruction rs_val rt_val result branch_taken wr_reg illegal
# The result column is only checked when wr_reg is 1
00221821 00000005 00000007 0000000c 0 1 0
00221822 00000003 00000005 fffffffe 0 1 0
00221824 ff00ff00 0ff00ff0 0f000f00 0 1 0
00221825 f0000000 0000000f f000000f 0 1 0
00221826 aaaaaaaa ffff0000 5555aaaa 0 1 0
0022182a ffffffff 00000001 00000001 0 1 0
0022182b ffffffff 00000001 00000000 0 1 0
2422fffc 00000010 00000000 0000000c 0 1 0
3022ff0f ffffffff 00000000 0000ff0f 0 1 0
34228000 12340000 00000000 12348000 0 1 0
3822ffff ffff0000 00000000 ffffffff 0 1 0
2822ffff fffffffe 00000000 00000001 0 1 0
2c22ffff 00000005 00000000 00000001 0 1 0
3c221234 00000000 00000000 12340000 0 1 0
00221900 00000000 80000001 00000010 0 1 0
00221a03 00000000 80000000 ff800000 0 1 0
00221fc2 00000000 80000000 00000001 0 1 0
00221807 ffffffe4 f0000000 ff000000 0 1 0
00221804 00000023 00000001 00000008 0 1 0
00221806 fffffff0 abcd0000 0000abcd 0 1 0
10220010 00000005 00000005 00000000 1 0 0
10220010 00000005 00000006 00000000 0 0 0
14220010 00000001 00000002 00000000 1 0 0
14220010 00000007 00000007 00000000 0 0 0
04200010 80000000 00000000 00000000 1 0 0
04200010 00000000 00000000 00000000 0 0 0
04210010 00000000 00000000 00000000 1 0 0
04210010 ffffffff 00000000 00000000 0 0 0
04300010 fffffff0 00000000 00000000 1 0 0
04310010 80000000 00000000 00000000 0 0 0
1c200010 00000001 00000000 00000000 1 0 0
1c200010 00000000 00000000 00000000 0 0 0
18200010 00000000 00000000 00000000 1 0 0
18200010 7fffffff 00000000 00000000 0 0 0
8c22fff8 00001000 00000000 00000ff8 0 1 0
ac220010 00002000 00000000 00002010 0 1 0
00220018 fffffffd 00000007 00000000 0 0 0
00001810 00000000 00000000 ffffffff 0 1 0
00001812 00000000 00000000 ffffffeb 0 1 0
00220019 ffffffff ffffffff 00000000 0 0 0
00001812 00000000 00000000 00000001 0 1 0
00001810 00000000 00000000 fffffffe 0 1 0
0022001a fffffff9 00000002 00000000 0 0 0
00001812 00000000 00000000 fffffffd 0 1 0
00001810 00000000 00000000 ffffffff 0 1 0
0022001b 00000064 00000007 00000000 0 0 0
00001810 00000000 00000000 00000002 0 1 0
00001812 00000000 00000000 0000000e 0 1 0
0022001a fffffff9 00000000 00000000 0 0 0
00001810 00000000 00000000 fffffff9 0 1 0
00001812 00000000 00000000 ffffffff 0 1 0
00200011 13579bdf 00000000 00000000 0 0 0
00200013 2468ace0 00000000 00000000 0 0 0
00001810 00000000 00000000 13579bdf 0 1 0
00001812 00000000 00000000 2468ace0 0 1 0
00220018 00000002 00000003 00000000 0 0 0
00200013 0badf00d 00000000 00000000 0 0 0
00001810 00000000 00000000 00000000 0 1 0
00001812 00000000 00000000 0badf00d 0 1 0
fc000000 00000000 00000000 00000000 0 0 1
00221801 00000000 00000000 00000000 0 0 1
04250010 80000000 00000000 00000000 0 0 1
1c220010 00000001 00000000 00000000 0 0 1

// ==== verilog.f ====
design/mips_exec_pkg.sv
design/instr_decoder.sv
design/int_alu.sv
design/muldiv_unit.sv
design/hilo_regs.sv
design/mips_execute.sv
testbench/mips_execute_tb.sv

// ==== Makefile ====
TOP := mips_execute_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
